/* sim/fetch_tests.txt */
# M <word address hex> <32-bit memory word hex>
# T <test name> <start address hex> <ready mode: always | lfsr>
M 010 10050100
M 011 200A0000
M 012 240F0201
M 013 EC4100FF
M 014 1C120300
M 015 08000000
M 040 04000000
M 041 29FD1234
M 042 10050100
M 043 200A0000
M 044 240F0201
M 04f 1C120300
M 050 2C4100FF
M 05f 14810010
M 060 30870000
M 063 C8000000
M 0f8 14810010
M 0f9 30870000
M 0fa 1802BEEF
M 0fb 20890001
M 0fc 27FE0002
M 0fd 08000000
T short 010 always
T long 040 always
T stall 010 lfsr
T restart_hit 012 always
T window_shift 05c lfsr
T restart_miss 0f8 lfsr
T tail_hit 0fb always

/* tb.f */
+incdir+hdl
hdl/ap_pkg.sv
hdl/prog_counter.sv
hdl/ins_cache.sv
hdl/isa_burst_reader.sv
hdl/ap_fetch_top.sv
sim/isa_mem_model.sv
sim/ap_fetch_tb.sv

/* Makefile */
TOP = ap_fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "Simulation did not complete"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* sim/ap_fetch_tb.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module ap_fetch_tb;

    localparam int MAX_TESTS = 16;

    logic                           clk;
    logic                           rst;
    logic                           start;
    logic [`AP_PC_W-1:0]            start_addr;
    logic                           ins_ready;
    ap_pkg::instruction_t           ins;
    logic                           ins_valid;
    logic                           done;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [`AP_PC_W-1:0]            wb_adr;
    logic [31:0]                    wb_dat_miso;
    logic                           wb_ack;
    logic                           mem_stall = 1'b0;

    logic [31:0]                    image [0:`AP_PROG_WORDS-1];
    string                          test_name [0:MAX_TESTS-1];
    int                             test_start [0:MAX_TESTS-1];
    logic                           test_stall [0:MAX_TESTS-1];
    int                             num_tests;

    logic [31:0]                    ready_lfsr = 32'h9a05;
    logic [31:0]                    wait_lfsr  = 32'h9a05;
    int                             watchdog_cycles = 0;

    int                             bursts = 0;
    int                             idle_cycles = 1000;
    int                             first_adr = -1;

    // Expected cache window
    int                             ref_tag;
    int                             ref_len;

    ap_fetch_top dut0
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_addr  (start_addr),
        .done        (done),
        .ins         (ins),
        .ins_valid   (ins_valid),
        .ins_ready   (ins_ready),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_miso (wb_dat_miso),
        .wb_ack      (wb_ack)
    );

    isa_mem_model mem0
    (
        .clk      (clk),
        .rst      (rst),
        .cyc      (wb_cyc),
        .stb      (wb_stb),
        .we       (wb_we),
        .adr      (wb_adr),
        .dat_miso (wb_dat_miso),
        .ack      (wb_ack),
        .stall    (mem_stall)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Opcode ABS in every unloaded word
    function automatic logic [31:0] fill_word(input int a);
        fill_word = 32'h3000_0000 ^ (a * 32'h0001_0101);
    endfunction

    function automatic ap_pkg::instruction_t image_ins(input int a);
        image_ins = ap_pkg::instruction_t'(image[a][`AP_INS_W-1:0]);
    endfunction

    function automatic int program_length(input int s);
        ap_pkg::instruction_t w;
        for (int a = s; a < `AP_PROG_WORDS; a++)
        begin
            w = image_ins(a);
            if (w.opcode == ap_pkg::RET)
                return a - s + 1;
        end
        return 0;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_ins(input string name, input ap_pkg::instruction_t exp,
                             input ap_pkg::instruction_t act);
        if (act !== exp)
            fail_stop($sformatf("ERR %s: expected ins %h, actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp)
            fail_stop($sformatf("ERR %s: %s expected %0d, actual %0d", name, what, exp, act));
    endtask

    task automatic read_tests();
        int              fd;
        int              code;
        int              a;
        logic [31:0]     d;
        logic [8*16-1:0] kind;
        logic [8*16-1:0] tok;
        logic [8*16-1:0] mode;
        logic [8*80-1:0] line;
        fd = $fopen("sim/fetch_tests.txt", "r");
        if (fd == 0)
            fail_stop("Could not open sim/fetch_tests.txt");
        num_tests = 0;
        forever
        begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1)
                break;
            if (kind == "#")
            begin
                code = $fgets(line, fd);
            end
            else if (kind == "M")
            begin
                code = $fscanf(fd, "%h %h", a, d);
                if (code != 2 || a >= `AP_PROG_WORDS)
                    fail_stop("Bad memory line in the test file");
                image[a] = d;
            end
            else if (kind == "T")
            begin
                code = $fscanf(fd, "%s %h %s", tok, a, mode);
                if (code != 3 || num_tests >= MAX_TESTS || (mode != "always" && mode != "lfsr"))
                    fail_stop("Bad test line in the test file");
                test_name[num_tests]  = string'(tok);
                test_start[num_tests] = a;
                test_stall[num_tests] = (mode == "lfsr");
                num_tests++;
            end
            else
            begin
                fail_stop("Unknown line type in the test file");
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        ap_pkg::instruction_t exp_q [$];
        string                name;
        int                   a;
        int                   exp_bursts;
        int                   exp_first;
        int                   got;
        int                   extra;
        bit                   pending;
        name       = test_name[t];
        exp_bursts = 0;
        exp_first  = -1;
        // Each miss refills a window based at the missing address
        for (a = test_start[t]; a < test_start[t] + program_length(test_start[t]); a++)
        begin
            if (!(a >= ref_tag && a < ref_tag + ref_len))
            begin
                if (exp_bursts == 0)
                    exp_first = a;
                exp_bursts++;
                ref_tag = a;
                ref_len = (`AP_PROG_WORDS - a < `AP_CACHE_DEPTH) ?
                          `AP_PROG_WORDS - a : `AP_CACHE_DEPTH;
            end
            exp_q.push_back(image_ins(a));
        end

        bursts    = 0;
        first_adr = -1;
        got       = 0;
        pending   = 0;
        @(negedge clk);
        start      = 1'b1;
        start_addr = test_start[t][`AP_PC_W-1:0];
        @(negedge clk);
        start = 1'b0;

        forever
        begin
            @(negedge clk);
            if (done)
                break;
            if (pending && !ins_valid)
                fail_stop($sformatf("%s: instruction withdrawn before it was accepted", name));
            if (test_stall[t])
            begin
                ins_ready  = ready_lfsr[0];
                ready_lfsr = lfsr_next(ready_lfsr);
            end
            else
            begin
                ins_ready = 1'b1;
            end
            if (ins_valid)
            begin
                if (got >= exp_q.size())
                    fail_stop($sformatf("%s: instruction delivered after RET", name));
                check_ins(name, exp_q[got], ins);     // Same word until it is accepted
                if (ins_ready)
                begin
                    got++;
                    pending = 0;
                end
                else
                begin
                    pending = 1;
                end
            end
        end
        check_count(name, "instructions", exp_q.size(), got);

        extra = 0;
        repeat (8)
        begin
            @(negedge clk);
            if (ins_valid)
                extra++;
        end
        check_count(name, "ins_valid after done", 0, extra);
        check_count(name, "bursts", exp_bursts, bursts);
        if (exp_bursts > 0)
            check_count(name, "first wb_adr", exp_first, first_adr);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Wait states for the memory
    always @(negedge clk)
    begin
        mem_stall = wait_lfsr[0];
        wait_lfsr = lfsr_next(wait_lfsr);
    end

    // A burst starts on wb_cyc after more than the one idle clock between words
    always @(negedge clk)
    begin
        if (wb_cyc)
        begin
            if (wb_we)
                fail_stop("Write cycle on the read-only instruction port");
            if (idle_cycles > 1)
            begin
                bursts++;
                if (first_adr < 0)
                    first_adr = int'(wb_adr);
            end
            idle_cycles = 0;
        end
        else if (idle_cycles < 1000)
        begin
            idle_cycles++;
        end
    end

    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_stop($sformatf("Timeout: tests did not finish within %0d cycles", watchdog_cycles));
    end

    initial
    begin
        int total;
        rst        = 1'b0;
        start      = 1'b0;
        start_addr = '0;
        ins_ready  = 1'b0;
        ref_tag    = 0;
        ref_len    = 0;
        for (int a = 0; a < `AP_PROG_WORDS; a++)
            image[a] = fill_word(a);
        read_tests();
        if (num_tests == 0)
            fail_stop("The test file holds no tests");
        total = 0;
        for (int t = 0; t < num_tests; t++)
        begin
            if (program_length(test_start[t]) == 0)
                fail_stop($sformatf("%s: no RET after the start address", test_name[t]));
            total += program_length(test_start[t]);
        end
        watchdog_cycles = 400 * total;
        for (int a = 0; a < `AP_PROG_WORDS; a++)
            mem0.load_word(a, image[a]);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        check_count("after_reset", "ins_valid", 0, int'(ins_valid));
        check_count("after_reset", "done", 0, int'(done));
        check_count("after_reset", "wb_cyc", 0, int'(wb_cyc));
        check_count("after_reset", "wb_stb", 0, int'(wb_stb));

        for (int t = 0; t < num_tests; t++)
            run_test(t);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sim/isa_mem_model.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module isa_mem_model
(
    input  logic                    clk,
    input  logic                    rst,

    // Wishbone classic slave, read only
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [`AP_PC_W-1:0]     adr,
    output logic [31:0]             dat_miso,
    output logic                    ack,

    input  logic                    stall      // Inserts a wait state when high
);

    localparam int AW = $clog2(`AP_PROG_WORDS);

    logic [31:0]                    mem [0:`AP_PROG_WORDS-1];

    task automatic load_word(input int addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ack      <= 1'b0;
            dat_miso <= '0;
        end
        else
        begin
            ack <= 1'b0;    // Single cycle ack
            if (cyc && stb && !we && !ack && !stall)
            begin
                ack <= 1'b1;
                if (adr < `AP_PROG_WORDS)
                    dat_miso <= mem[adr[AW-1:0]];
                else
                    dat_miso <= {6'h2a, 16'h0000, adr};   // Outside the image
            end
        end
    end

endmodule

/* hdl/ap_fetch_top.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module ap_fetch_top
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    start,
    input  logic [`AP_PC_W-1:0]     start_addr,
    output logic                    done,

    // To the controller
    output ap_pkg::instruction_t    ins,
    output logic                    ins_valid,
    input  logic                    ins_ready,

    // Instruction memory
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`AP_PC_W-1:0]     wb_adr,
    input  logic [31:0]             wb_dat_miso,
    input  logic                    wb_ack
);

    logic [`AP_PC_W-1:0]            pc;
    logic                           fetch_req;
    logic                           refill_start;
    ap_pkg::refill_req_t            refill_req;
    logic                           fill_valid;
    logic [`AP_IDX_W-1:0]           fill_index;
    ap_pkg::instruction_t           fill_data;
    logic                           refill_done;

    prog_counter u_prog_counter
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_addr (start_addr),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .pc         (pc),
        .fetch_req  (fetch_req),
        .done       (done)
    );

    ins_cache u_ins_cache
    (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .fetch_req    (fetch_req),
        .ins_ready    (ins_ready),
        .ins          (ins),
        .ins_valid    (ins_valid),
        .refill_start (refill_start),
        .refill_req   (refill_req),
        .fill_valid   (fill_valid),
        .fill_index   (fill_index),
        .fill_data    (fill_data),
        .refill_done  (refill_done)
    );

    isa_burst_reader u_isa_burst_reader
    (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .refill_req   (refill_req),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_miso  (wb_dat_miso),
        .wb_ack       (wb_ack),
        .fill_valid   (fill_valid),
        .fill_index   (fill_index),
        .fill_data    (fill_data),
        .refill_done  (refill_done)
    );

endmodule

/* hdl/isa_burst_reader.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module isa_burst_reader
(
    input  logic                    clk,
    input  logic                    rst,

    // Request from the cache
    input  logic                    refill_start,
    input  ap_pkg::refill_req_t     refill_req,

    // Wishbone classic master
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`AP_PC_W-1:0]     wb_adr,
    input  logic [31:0]             wb_dat_miso,
    input  logic                    wb_ack,

    // Words into the cache window
    output logic                    fill_valid,
    output logic [`AP_IDX_W-1:0]    fill_index,
    output ap_pkg::instruction_t    fill_data,
    output logic                    refill_done
);

    logic                           active;
    logic [`AP_CNT_W-1:0]           words_left;
    logic [`AP_IDX_W-1:0]           word_idx;
    logic                           acked;

    assign acked  = wb_cyc && wb_ack;
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;      // Read only port

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            active      <= 1'b0;
            wb_cyc      <= 1'b0;
            wb_adr      <= '0;
            words_left  <= '0;
            word_idx    <= '0;
            fill_valid  <= 1'b0;
            refill_done <= 1'b0;
        end
        else
        begin
            fill_valid  <= acked;
            refill_done <= 1'b0;
            if (refill_start && !active)
            begin
                active     <= 1'b1;
                wb_cyc     <= 1'b1;
                wb_adr     <= refill_req.base;
                words_left <= refill_req.count;
                word_idx   <= '0;
            end
            else if (acked)
            begin
                // Close the cycle, next word after one idle clock
                wb_cyc     <= 1'b0;
                wb_adr     <= wb_adr + 1'b1;
                word_idx   <= word_idx + 1'b1;
                words_left <= words_left - 1'b1;
            end
            else if (active && !wb_cyc)
            begin
                if (words_left == '0)
                begin
                    active      <= 1'b0;
                    refill_done <= 1'b1;   // One clock after the last fill_valid
                end
                else
                begin
                    wb_cyc <= 1'b1;
                end
            end
        end
    end

    // Instruction is the low part of the bus word
    always_ff @(posedge clk)
    begin
        if (acked)
        begin
            fill_data  <= wb_dat_miso[`AP_INS_W-1:0];
            fill_index <= word_idx;
        end
    end

endmodule

/* hdl/ins_cache.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module ins_cache
(
    input  logic                    clk,
    input  logic                    rst,

    // Program counter side
    input  logic [`AP_PC_W-1:0]     pc,
    input  logic                    fetch_req,
    input  logic                    ins_ready,
    output ap_pkg::instruction_t    ins,
    output logic                    ins_valid,

    // Burst reader side
    output logic                    refill_start,
    output ap_pkg::refill_req_t     refill_req,
    input  logic                    fill_valid,
    input  logic [`AP_IDX_W-1:0]    fill_index,
    input  ap_pkg::instruction_t    fill_data,
    input  logic                    refill_done
);

    localparam logic [`AP_PC_W:0]   PROG_END  = `AP_PROG_WORDS;
    localparam logic [`AP_PC_W:0]   WIN_DEPTH = `AP_CACHE_DEPTH;

    ap_pkg::instruction_t           mem [0:`AP_CACHE_DEPTH-1];
    ap_pkg::cache_state_e           state;

    logic [`AP_PC_W-1:0]            tag;        // Address of window word 0
    logic [`AP_CNT_W-1:0]           valid_len;
    logic [`AP_PC_W-1:0]            held_pc;    // Address of the instruction in ins
    logic [`AP_PC_W-1:0]            offset;
    logic [`AP_PC_W:0]              remain;
    logic [`AP_CNT_W-1:0]           fill_cnt;
    logic                           hit;

    assign offset    = pc - tag;
    assign hit       = (pc >= tag) && (offset < {{(`AP_PC_W-`AP_CNT_W){1'b0}}, valid_len});
    assign ins_valid = (state == ap_pkg::SEND);

    // Refill length, clipped at the end of the program
    always_comb
    begin
        remain = PROG_END - {1'b0, pc};
        if ({1'b0, pc} >= PROG_END)
        begin
            fill_cnt = 1;   // Past the image, fetch a single word
        end
        else if (remain > WIN_DEPTH)
        begin
            fill_cnt = WIN_DEPTH[`AP_CNT_W-1:0];
        end
        else
        begin
            fill_cnt = remain[`AP_CNT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state        <= ap_pkg::IDLE;
            tag          <= '0;
            valid_len    <= '0;
            refill_start <= 1'b0;
        end
        else
        begin
            refill_start <= 1'b0;
            case (state)
                ap_pkg::IDLE:
                begin
                    if (fetch_req)
                        state <= ap_pkg::LOOKUP;
                end
                ap_pkg::LOOKUP:
                begin
                    if (!fetch_req)
                    begin
                        state <= ap_pkg::IDLE;
                    end
                    else if (hit)
                    begin
                        state <= ap_pkg::SEND;
                    end
                    else
                    begin
                        refill_start <= 1'b1;
                        state        <= ap_pkg::REFILL;
                    end
                end
                ap_pkg::REFILL:
                begin
                    // New window becomes valid once the last word is in
                    if (refill_done)
                    begin
                        tag       <= refill_req.base;
                        valid_len <= refill_req.count;
                        state     <= ap_pkg::LOOKUP;
                    end
                end
                ap_pkg::SEND:
                begin
                    if (ins_ready || pc != held_pc)
                        state <= ap_pkg::LOOKUP;
                end
                default: state <= ap_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_valid)
            mem[fill_index] <= fill_data;

        if (state == ap_pkg::LOOKUP && hit)
        begin
            ins     <= mem[offset[`AP_IDX_W-1:0]];
            held_pc <= pc;
        end

        // Miss at pc refills a window starting at pc
        if (state == ap_pkg::LOOKUP && !hit)
        begin
            refill_req.base  <= pc;
            refill_req.count <= fill_cnt;
        end
    end

endmodule

/* hdl/prog_counter.sv */
`timescale 1ns/10ps
`include "ap_consts.svh"

module prog_counter
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    start,
    input  logic [`AP_PC_W-1:0]     start_addr,

    // Instruction handshake, seen alongside the consumer
    input  ap_pkg::instruction_t    ins,
    input  logic                    ins_valid,
    input  logic                    ins_ready,

    output logic [`AP_PC_W-1:0]     pc,
    output logic                    fetch_req,
    output logic                    done
);

    logic                           accept;

    assign accept = fetch_req && ins_valid && ins_ready;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pc        <= '0;
            fetch_req <= 1'b0;
            done      <= 1'b0;
        end
        else if (start)
        begin
            // A start also restarts a running program
            pc        <= start_addr;
            fetch_req <= 1'b1;
            done      <= 1'b0;
        end
        else if (accept)
        begin
            pc <= pc + 1'b1;
            if (ins.opcode == ap_pkg::RET)
            begin
                fetch_req <= 1'b0;  // Program finished
                done      <= 1'b1;
            end
        end
    end

endmodule

/* hdl/ap_pkg.sv */
`include "ap_consts.svh"

package ap_pkg;

    typedef enum logic [`AP_OPCODE_W-1:0]
    {
        RESET       = 4'd1,
        RET         = 4'd2,
        LOADRBR     = 4'd4,
        LOADCBC     = 4'd5,
        STORERBR    = 4'd6,
        STORECBC    = 4'd7,
        COPY        = 4'd8,
        ADD         = 4'd9,
        SUB         = 4'd10,
        TSC         = 4'd11,
        ABS         = 4'd12
    } opcode_e;

    typedef enum logic [`AP_OPR2_W-1:0]
    {
        M_A         = 2'd1,
        M_B         = 2'd2,
        M_R         = 2'd3
    } operand2_e;

    typedef struct packed
    {
        opcode_e                        opcode;
        logic [`AP_CAM_ADDR_W-1:0]      cam_addr;
        operand2_e                      opr2;
        logic [`AP_MEM_ADDR_W-1:0]      mem_addr;
    } instruction_t;

    // Cache to burst reader
    typedef struct packed
    {
        logic [`AP_PC_W-1:0]            base;
        logic [`AP_CNT_W-1:0]           count;
    } refill_req_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, SEND} cache_state_e;

endpackage

/* hdl/ap_consts.svh */
`ifndef AP_CONSTS_SVH
`define AP_CONSTS_SVH

// Instruction fields, MSB first
`define AP_OPCODE_W         4
`define AP_CAM_ADDR_W       8
`define AP_OPR2_W           2
`define AP_MEM_ADDR_W       16

`define AP_INS_W            (`AP_OPCODE_W + `AP_CAM_ADDR_W + `AP_OPR2_W + `AP_MEM_ADDR_W)

// Word address into instruction memory
`define AP_PC_W             10

// One cache window
`define AP_CACHE_DEPTH      16
`define AP_IDX_W            4
`define AP_CNT_W            5   // Holds 0 .. AP_CACHE_DEPTH

// Instruction memory size in words
`define AP_PROG_WORDS       256

`endif
